// File: rtl/socPkg.sv
`default_nettype none

package socPkg;

    // bus geometry
    localparam int dataWidth   = 32;
    localparam int addrWidth   = 16;

    localparam int ramWords    = 1024;  // depth in 32-bit words

    localparam int irqLines    = 16;
    localparam int irqNumWidth = 4;

    // region codes, address[15:12]
    localparam logic [3:0] regionRam   = 4'd0;
    localparam logic [3:0] regionTimer = 4'd1;
    localparam logic [3:0] regionIrq   = 4'd2;

    // timer word offsets, address[4:2]
    localparam logic [2:0] timerCtrlReg    = 3'd0;  // bit 0 / bit 1 enable
    localparam logic [2:0] timerReload0Reg = 3'd1;
    localparam logic [2:0] timerReload1Reg = 3'd2;
    localparam logic [2:0] timerCount0Reg  = 3'd3;  // read only
    localparam logic [2:0] timerCount1Reg  = 3'd4;  // read only

    // interrupt controller word offsets
    localparam logic [2:0] irqMaskReg    = 3'd0;    // 1 enables a line
    localparam logic [2:0] irqPendingReg = 3'd1;    // read only

    typedef struct packed {
        logic                 read;
        logic                 write;
        logic [3:0]           bwe;
        logic [addrWidth-1:0] address;
        logic [dataWidth-1:0] writeData;
    } busReq_t;

    typedef struct packed {
        logic                 readValid;
        logic [dataWidth-1:0] readData;
    } busRsp_t;

endpackage

`default_nettype wire

// File: rtl/busInterconnect.sv
`timescale 1ns/1ps
`default_nettype none

module busInterconnect (
    input  logic            clk,
    input  logic            rstN,

    input  socPkg::busReq_t masterReq,
    output socPkg::busRsp_t masterRsp,

    output socPkg::busReq_t ramReq,
    output socPkg::busReq_t timerReq,
    output socPkg::busReq_t irqReq,

    input  socPkg::busRsp_t ramRsp,
    input  socPkg::busRsp_t timerRsp,
    input  socPkg::busRsp_t irqRsp
    );


    logic  [3:0]                   region;
    logic                          hitRam;
    logic                          hitTimer;
    logic                          hitIrq;
    logic                          unmapped;
    logic                          unmappedValid;   // answers a dead read ourselves
    logic  [socPkg::dataWidth-1:0] ramData;
    logic  [socPkg::dataWidth-1:0] timerData;
    logic  [socPkg::dataWidth-1:0] irqData;


    assign region   = masterReq.address[15:12];
    assign hitRam   = (region == socPkg::regionRam);
    assign hitTimer = (region == socPkg::regionTimer);
    assign hitIrq   = (region == socPkg::regionIrq);
    assign unmapped = !(hitRam || hitTimer || hitIrq);


    // address and data fan out as is, only strobes are steered
    always_comb begin
        ramReq         = masterReq;
        ramReq.read    = masterReq.read  & hitRam;
        ramReq.write   = masterReq.write & hitRam;

        timerReq       = masterReq;
        timerReq.read  = masterReq.read  & hitTimer;
        timerReq.write = masterReq.write & hitTimer;

        irqReq         = masterReq;
        irqReq.read    = masterReq.read  & hitIrq;
        irqReq.write   = masterReq.write & hitIrq;
    end


    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            unmappedValid <= 1'b0;
        end else begin
            unmappedValid <= masterReq.read & unmapped;   // unmapped writes just vanish
        end
    end


    // slaves may hold stale data, so mask each by its valid before merging
    assign ramData   = ramRsp.readValid   ? ramRsp.readData   : '0;
    assign timerData = timerRsp.readValid ? timerRsp.readData : '0;
    assign irqData   = irqRsp.readValid   ? irqRsp.readData   : '0;

    assign masterRsp.readValid = ramRsp.readValid | timerRsp.readValid |
                                 irqRsp.readValid | unmappedValid;
    assign masterRsp.readData  = ramData | timerData | irqData;   // zero for unmapped


    // equal latency everywhere means responses never collide
    oneResponder: assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({ramRsp.readValid, timerRsp.readValid, irqRsp.readValid, unmappedValid}));


endmodule

`default_nettype wire

// File: rtl/ram.sv
`timescale 1ns/1ps
`default_nettype none

module ram (
    input  logic            clk,
    input  logic            rstN,

    input  socPkg::busReq_t req,
    output socPkg::busRsp_t rsp
    );


    logic  [socPkg::dataWidth-1:0]         mem [socPkg::ramWords];
    logic  [$clog2(socPkg::ramWords)-1:0]  wordIndex;
    logic  [socPkg::dataWidth-1:0]         readData;
    logic                                  readValid;


    assign wordIndex = req.address[11:2];   // byte address to word


    // storage, write lands on the accepting edge
    always_ff @(posedge clk) begin
        if (req.write) begin
            for (int b = 0; b < socPkg::dataWidth / 8; b++) begin
                if (req.bwe[b]) begin
                    mem[wordIndex][8*b +: 8] <= req.writeData[8*b +: 8];
                end
            end
        end

        if (req.read) begin
            readData <= mem[wordIndex];
        end
    end


    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end


    assign rsp.readValid = readValid;
    assign rsp.readData  = readData;


endmodule

`default_nettype wire

// File: rtl/timer.sv
`timescale 1ns/1ps
`default_nettype none

module timer (
    input  logic            clk,
    input  logic            rstN,

    input  socPkg::busReq_t req,
    output socPkg::busRsp_t rsp,

    output logic  [1:0]     timerIrq
    );


    logic  [2:0]                   regIndex;
    logic  [1:0]                   ctrl;
    logic  [1:0]                   ctrlNext;       // enables as seen after this edge
    logic  [1:0]                   loadPending;
    logic  [socPkg::dataWidth-1:0] reload [2];
    logic  [socPkg::dataWidth-1:0] count  [2];
    logic  [socPkg::dataWidth-1:0] readData;
    logic                          readValid;


    assign regIndex = req.address[4:2];
    assign ctrlNext = (req.write && regIndex == socPkg::timerCtrlReg) ?
                      req.writeData[1:0] : ctrl;


    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrl        <= '0;
            loadPending <= '1;
            timerIrq    <= '0;
            for (int ch = 0; ch < 2; ch++) begin
                reload[ch] <= '0;
                count[ch]  <= '0;
            end
        end else begin
            ctrl <= ctrlNext;

            if (req.write && regIndex == socPkg::timerReload0Reg) begin
                reload[0] <= req.writeData;
            end
            if (req.write && regIndex == socPkg::timerReload1Reg) begin
                reload[1] <= req.writeData;
            end

            for (int ch = 0; ch < 2; ch++) begin
                timerIrq[ch] <= 1'b0;
                if (!ctrlNext[ch]) begin
                    loadPending[ch] <= 1'b1;           // count frozen, reload on enable
                end else if (loadPending[ch]) begin
                    count[ch]       <= reload[ch];
                    loadPending[ch] <= 1'b0;
                end else if (count[ch] == '0) begin
                    count[ch]    <= reload[ch];        // period is reload + 1
                    timerIrq[ch] <= 1'b1;
                end else begin
                    count[ch] <= count[ch] - 1'b1;
                end
            end
        end
    end


    // register readback
    always_ff @(posedge clk) begin
        if (req.read) begin
            case (regIndex)
                socPkg::timerCtrlReg:    readData <= {{(socPkg::dataWidth-2){1'b0}}, ctrl};
                socPkg::timerReload0Reg: readData <= reload[0];
                socPkg::timerReload1Reg: readData <= reload[1];
                socPkg::timerCount0Reg:  readData <= count[0];
                socPkg::timerCount1Reg:  readData <= count[1];
                default:                 readData <= '0;
            endcase
        end
    end


    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end


    assign rsp.readValid = readValid;
    assign rsp.readData  = readData;


    // disabling on the same edge as a zero crossing must swallow the pulse
    irqOnlyWhenEnabled: assert property (@(posedge clk) disable iff (!rstN)
        (timerIrq & ~ctrl) == 2'b00);


endmodule

`default_nettype wire

// File: rtl/interruptController.sv
`timescale 1ns/1ps
`default_nettype none

module interruptController (
    input  logic                             clk,
    input  logic                             rstN,

    input  socPkg::busReq_t                  req,
    output socPkg::busRsp_t                  rsp,

    input  logic  [socPkg::irqLines-1:0]     triggerInterrupt,
    input  logic                             interruptAcknowledge,
    input  logic  [socPkg::irqNumWidth-1:0]  ackNumber,
    output logic                             interruptRequest,
    output logic  [socPkg::irqNumWidth-1:0]  interruptNumber
    );


    typedef enum logic [1:0] {idleState, requestState, recoverState} state_t;

    state_t                           state;
    logic  [socPkg::irqLines-1:0]     pending;
    logic  [socPkg::irqLines-1:0]     mask;
    logic  [socPkg::irqLines-1:0]     active;
    logic  [socPkg::irqLines-1:0]     clearMask;
    logic  [socPkg::irqNumWidth-1:0]  nextNumber;
    logic                             ackMatch;
    logic  [2:0]                      regIndex;
    logic  [socPkg::dataWidth-1:0]    readData;
    logic                             readValid;


    assign regIndex         = req.address[4:2];
    assign active           = pending & mask;
    assign interruptRequest = (state == requestState);
    assign ackMatch         = interruptRequest && interruptAcknowledge &&
                              (ackNumber == interruptNumber);   // wrong number ignored


    // lowest line wins
    always_comb begin
        nextNumber = '0;
        for (int i = socPkg::irqLines - 1; i >= 0; i--) begin
            if (active[i]) begin
                nextNumber = i[socPkg::irqNumWidth-1:0];
            end
        end
    end

    always_comb begin
        clearMask = '0;
        if (ackMatch) begin
            clearMask[interruptNumber] = 1'b1;
        end
    end


    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state           <= idleState;
            pending         <= '0;
            mask            <= '0;
            interruptNumber <= '0;
        end else begin
            pending <= (pending & ~clearMask) | triggerInterrupt;  // new trigger beats clear

            if (req.write && regIndex == socPkg::irqMaskReg) begin
                mask <= req.writeData[socPkg::irqLines-1:0];
            end

            case (state)
                idleState: begin
                    if (|active) begin
                        state           <= requestState;
                        interruptNumber <= nextNumber;
                    end
                end
                requestState: begin
                    if (ackMatch) begin
                        state <= recoverState;
                    end
                end
                default: state <= idleState;   // one quiet cycle
            endcase
        end
    end


    always_ff @(posedge clk) begin
        if (req.read) begin
            case (regIndex)
                socPkg::irqMaskReg:
                    readData <= {{(socPkg::dataWidth-socPkg::irqLines){1'b0}}, mask};
                socPkg::irqPendingReg:
                    readData <= {{(socPkg::dataWidth-socPkg::irqLines){1'b0}}, pending};
                default:
                    readData <= '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            readValid <= 1'b0;
        end else begin
            readValid <= req.read;
        end
    end

    assign rsp.readValid = readValid;
    assign rsp.readData  = readData;


    numberHeld: assert property (@(posedge clk) disable iff (!rstN)
        interruptRequest |=> !interruptRequest || $stable(interruptNumber));


endmodule

`default_nettype wire

// File: rtl/socCore.sv
`timescale 1ns/1ps
`default_nettype none

module socCore (
    input  logic                             clk,
    input  logic                             rstN,

    input  socPkg::busReq_t                  busReq,
    output socPkg::busRsp_t                  busRsp,

    input  logic                             interruptAcknowledge,
    input  logic  [socPkg::irqNumWidth-1:0]  ackNumber,
    output logic                             interruptRequest,
    output logic  [socPkg::irqNumWidth-1:0]  interruptNumber
    );


    // slave side of the interconnect
    socPkg::busReq_t  ramReq;
    socPkg::busRsp_t  ramRsp;
    socPkg::busReq_t  timerReq;
    socPkg::busRsp_t  timerRsp;
    socPkg::busReq_t  irqReq;
    socPkg::busRsp_t  irqRsp;

    logic  [1:0]                   timerIrq;
    logic  [socPkg::irqLines-1:0]  triggerInterrupt;


    // lines 0 and 1 from the timer channels, the rest unused
    assign triggerInterrupt = {{(socPkg::irqLines-2){1'b0}}, timerIrq};


    busInterconnect
    busInterconnect(
        .clk,
        .rstN,
        .masterReq              (busReq),
        .masterRsp              (busRsp),
        .ramReq,
        .timerReq,
        .irqReq,
        .ramRsp,
        .timerRsp,
        .irqRsp
    );


    ram
    ram(
        .clk,
        .rstN,
        .req                    (ramReq),
        .rsp                    (ramRsp)
    );


    timer
    timer(
        .clk,
        .rstN,
        .req                    (timerReq),
        .rsp                    (timerRsp),
        .timerIrq
    );


    interruptController
    interruptController(
        .clk,
        .rstN,
        .req                    (irqReq),
        .rsp                    (irqRsp),
        .triggerInterrupt,
        .interruptAcknowledge,
        .ackNumber,
        .interruptRequest,
        .interruptNumber
    );


endmodule

`default_nettype wire

// File: tests/socCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module socCoreTb;

    localparam int clkPeriod = 8;

    typedef enum logic [2:0] {opWrite, opRead, opPoll, opCount, opAck, opWaitIrq, opIdle} op_t;

    typedef struct packed {
        int          test;
        op_t         op;
        logic [15:0] address;
        logic [3:0]  bwe;
        logic [31:0] data;      // write data, poll mask, gap, ack number or idle cycles
        logic [31:0] expected;
        logic        flag;      // random data on writes, model lookup on reads
    } entry_t;

    typedef struct packed {
        logic [31:0] data;
        logic [31:0] cycle;     // cycle in which the read was driven
        logic        check;
    } readItem_t;

    logic                             clk;
    logic                             rstN;
    socPkg::busReq_t                  busReq;
    socPkg::busRsp_t                  busRsp;
    logic                             interruptAcknowledge;
    logic  [socPkg::irqNumWidth-1:0]  ackNumber;
    logic                             interruptRequest;
    logic  [socPkg::irqNumWidth-1:0]  interruptNumber;

    entry_t      steps[$];
    readItem_t   expectQ[$];
    logic [31:0] ramModel [socPkg::ramWords];
    logic [31:0] lastData;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          failedTests = 0;
    int          seed = 32'hb91b;
    bit          tableReady = 1'b0;

    socCore uut (
        .clk,
        .rstN,
        .busReq,
        .busRsp,
        .interruptAcknowledge,
        .ackNumber,
        .interruptRequest,
        .interruptNumber
    );

    initial clk = 1'b0;
    always #(clkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // response checker, outputs are all registered so negedge is quiet
    always @(negedge clk) begin
        readItem_t head;
        if (rstN && busRsp.readValid) begin
            lastData = busRsp.readData;
            assert (expectQ.size() != 0) else begin
                $display("ERROR at %0t: readValid with no read outstanding", $time);
                errors++;
            end
            if (expectQ.size() != 0) begin
                head = expectQ.pop_front();
                if (head.check) begin
                    checks++;
                    assert (busRsp.readData == head.data) else begin
                        $display("MISMATCH at %0t: read data %h, expected %h",
                                 $time, busRsp.readData, head.data);
                        errors++;
                    end
                end
                assert (cycle == head.cycle + 1) else begin
                    $display("ERROR at %0t: readValid came late for a read", $time);
                    errors++;
                end
            end
        end else if (expectQ.size() != 0 && cycle > expectQ[0].cycle + 1) begin
            head = expectQ.pop_front();
            assert (1'b0) else begin
                $display("ERROR at %0t: a read got no readValid", $time);
                errors++;
            end
        end
    end

    task automatic driveIdle();
        busReq               = '0;
        interruptAcknowledge = 1'b0;
        ackNumber            = '0;
    endtask

    task automatic busWrite(input logic [15:0] address, input logic [3:0] bwe,
                            input logic [31:0] data);
        @(negedge clk);
        driveIdle();
        busReq.write     = 1'b1;
        busReq.bwe       = bwe;
        busReq.address   = address;
        busReq.writeData = data;
        if (address[15:12] == socPkg::regionRam) begin
            for (int b = 0; b < 4; b++) begin
                if (bwe[b]) ramModel[address[11:2]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic busRead(input logic [15:0] address, input logic [31:0] expected,
                           input logic check);
        readItem_t item;
        @(negedge clk);
        driveIdle();
        busReq.read    = 1'b1;
        busReq.address = address;
        item.data      = expected;
        item.cycle     = cycle;
        item.check     = check;
        expectQ.push_back(item);
    endtask

    // idle the bus until every outstanding read has been answered
    task automatic drainReads();
        @(negedge clk);
        driveIdle();
        repeat (2) @(posedge clk);
    endtask

    task automatic readBack(input logic [15:0] address, output logic [31:0] data);
        busRead(address, '0, 1'b0);
        drainReads();
        data = lastData;
    endtask

    task automatic pollUntil(input logic [15:0] address, input logic [31:0] mask,
                             input logic [31:0] expected);
        logic [31:0] data;
        bit          found;
        found = 1'b0;
        for (int i = 0; i < 100 && !found; i++) begin
            readBack(address, data);
            found = ((data & mask) == expected);
        end
        checks++;
        assert (found) else begin
            $display("ERROR at %0t: register %h never showed %h under mask %h",
                     $time, address, expected, mask);
            errors++;
        end
    endtask

    task automatic countMoving(input logic [15:0] address, input int gap,
                               input logic [31:0] bound);
        logic [31:0] first;
        logic [31:0] second;
        readBack(address, first);
        repeat (gap) @(posedge clk);
        readBack(address, second);
        checks++;
        assert (second != first && first <= bound && second <= bound) else begin
            $display("MISMATCH at %0t: count went from %0d to %0d", $time, first, second);
            errors++;
        end
    endtask

    task automatic ackInterrupt(input logic [3:0] number, input logic expectDrop);
        logic [3:0] numberBefore;
        @(negedge clk);
        driveIdle();
        numberBefore         = interruptNumber;
        interruptAcknowledge = 1'b1;
        ackNumber            = number;
        @(negedge clk);
        driveIdle();
        checks++;
        if (expectDrop) begin
            assert (!interruptRequest) else begin
                $display("MISMATCH at %0t: request still high after ack %0d", $time, number);
                errors++;
            end
            @(negedge clk);
            assert (!interruptRequest) else begin
                $display("MISMATCH at %0t: request rose again with no gap", $time);
                errors++;
            end
        end else begin
            assert (interruptRequest && interruptNumber == numberBefore) else begin
                $display("MISMATCH at %0t: wrong ack %0d changed request %b number %0d",
                         $time, number, interruptRequest, interruptNumber);
                errors++;
            end
        end
    endtask

    task automatic waitForRequest(input logic [3:0] number);
        int waited;
        waited = 0;
        @(negedge clk);
        driveIdle();
        while (!interruptRequest && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        checks++;
        assert (interruptRequest) else begin
            $display("ERROR at %0t: no interrupt request within 50 cycles", $time);
            errors++;
        end
        if (interruptRequest) begin
            assert (interruptNumber == number) else begin
                $display("MISMATCH at %0t: interrupt number %0d, expected %0d",
                         $time, interruptNumber, number);
                errors++;
            end
        end
    endtask

    task automatic idleCheck(input int cycles, input logic expectRequest);
        int bad;
        bad = 0;
        @(negedge clk);
        driveIdle();
        repeat (cycles) begin
            @(negedge clk);
            if (interruptRequest != expectRequest) bad++;
        end
        checks++;
        assert (bad == 0) else begin
            $display("MISMATCH at %0t: interruptRequest was %b in %0d of %0d cycles",
                     $time, !expectRequest, bad, cycles);
            errors++;
        end
    endtask

    task automatic addEntry(input int test, input op_t op, input logic [15:0] address,
                            input logic [3:0] bwe, input logic [31:0] data,
                            input logic [31:0] expected, input logic flag);
        entry_t step;
        step = '{test, op, address, bwe, data, expected, flag};
        steps.push_back(step);
    endtask

    task automatic buildTable();
        addEntry(1, opRead,    16'h2004, 4'h0, 0, 0, 1'b0);    // pending
        addEntry(1, opRead,    16'h1000, 4'h0, 0, 0, 1'b0);    // timer ctrl
        addEntry(2, opWrite,   16'h0000, 4'hf, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0004, 4'hf, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0010, 4'hf, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0ffc, 4'hf, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0004, 4'h3, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0010, 4'ha, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0000, 4'h8, 0, 0, 1'b1);
        addEntry(2, opWrite,   16'h0ffc, 4'h1, 0, 0, 1'b1);
        addEntry(2, opRead,    16'h0ffc, 4'h0, 0, 0, 1'b1);    // right after its write
        addEntry(2, opRead,    16'h0000, 4'h0, 0, 0, 1'b1);
        addEntry(2, opRead,    16'h0004, 4'h0, 0, 0, 1'b1);
        addEntry(2, opRead,    16'h0010, 4'h0, 0, 0, 1'b1);
        addEntry(2, opRead,    16'h0ffc, 4'h0, 0, 0, 1'b1);
        addEntry(2, opRead,    16'h0004, 4'h0, 0, 0, 1'b1);
        addEntry(3, opRead,    16'h5000, 4'h0, 0, 0, 1'b0);
        addEntry(3, opWrite,   16'h5010, 4'hf, 32'h1234_5678, 0, 1'b0);
        addEntry(3, opRead,    16'h0010, 4'h0, 0, 0, 1'b1);    // same word index, untouched
        addEntry(3, opRead,    16'h5ffc, 4'h0, 0, 0, 1'b0);
        addEntry(4, opWrite,   16'h1004, 4'hf, 20, 0, 1'b0);
        addEntry(4, opWrite,   16'h1000, 4'hf, 1, 0, 1'b0);
        addEntry(4, opCount,   16'h100c, 4'h0, 7, 20, 1'b0);
        addEntry(4, opPoll,    16'h2004, 4'h0, 1, 1, 1'b0);
        addEntry(4, opIdle,    16'h0000, 4'h0, 10, 0, 1'b0);   // line masked
        addEntry(4, opWrite,   16'h1000, 4'hf, 0, 0, 1'b0);
        addEntry(5, opWrite,   16'h1004, 4'hf, 3, 0, 1'b0);
        addEntry(5, opWrite,   16'h1008, 4'hf, 5, 0, 1'b0);
        addEntry(5, opWrite,   16'h1000, 4'hf, 3, 0, 1'b0);
        addEntry(5, opPoll,    16'h2004, 4'h0, 3, 3, 1'b0);
        addEntry(5, opWrite,   16'h1000, 4'hf, 0, 0, 1'b0);
        addEntry(5, opIdle,    16'h0000, 4'h0, 4, 0, 1'b0);
        addEntry(5, opWrite,   16'h2000, 4'hf, 3, 0, 1'b0);    // unmask both
        addEntry(5, opWaitIrq, 16'h0000, 4'h0, 0, 0, 1'b0);
        addEntry(5, opAck,     16'h0000, 4'h0, 0, 1, 1'b0);
        addEntry(5, opWaitIrq, 16'h0000, 4'h0, 0, 1, 1'b0);
        addEntry(6, opAck,     16'h0000, 4'h0, 0, 0, 1'b0);    // wrong number
        addEntry(6, opAck,     16'h0000, 4'h0, 1, 1, 1'b0);
        addEntry(6, opIdle,    16'h0000, 4'h0, 20, 0, 1'b0);
        addEntry(6, opRead,    16'h2004, 4'h0, 0, 0, 1'b0);
    endtask

    task automatic applyEntry(input entry_t step);
        logic [31:0] data;
        data = step.data;
        if (step.op == opWrite && step.flag) data = $random(seed);
        case (step.op)
            opWrite:   busWrite(step.address, step.bwe, data);
            opRead:    busRead(step.address,
                               step.flag ? ramModel[step.address[11:2]] : step.expected, 1'b1);
            opPoll:    pollUntil(step.address, step.data, step.expected);
            opCount:   countMoving(step.address, step.data, step.expected);
            opAck:     ackInterrupt(step.data[3:0], step.expected[0]);
            opWaitIrq: waitForRequest(step.expected[3:0]);
            opIdle:    idleCheck(step.data, step.expected[0]);
            default:   driveIdle();
        endcase
    endtask

    task automatic closeTest(input int test, input int startErrors);
        if (errors == startErrors) begin
            $display("test %0d ok", test);
        end else begin
            $display("test %0d FAILED with %0d errors", test, errors - startErrors);
            failedTests++;
        end
    endtask

    initial begin
        int curTest;
        int testErrors;
        rstN = 1'b0;
        driveIdle();
        buildTable();
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        curTest    = 1;
        testErrors = errors;
        @(negedge clk);
        checks++;
        assert (!busRsp.readValid && !interruptRequest) else begin
            $display("MISMATCH at %0t: readValid or interruptRequest high after reset", $time);
            errors++;
        end

        foreach (steps[i]) begin
            if (steps[i].test != curTest) begin
                drainReads();
                closeTest(curTest, testErrors);
                curTest    = steps[i].test;
                testErrors = errors;
            end
            applyEntry(steps[i]);
        end
        drainReads();
        closeTest(curTest, testErrors);

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 curTest, failedTests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog scaled by the table length
    initial begin
        wait (tableReady);
        #(steps.size() * 200 * clkPeriod);
        $display("ERROR: simulation timed out before the table finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
rtl/socPkg.sv
rtl/busInterconnect.sv
rtl/ram.sv
rtl/timer.sv
rtl/interruptController.sv
rtl/socCore.sv
tests/socCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the socCore testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module socCoreTb \
    -f all.f -o socCoreSim \
    && ./obj_dir/socCoreSim > sim.log \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "Some tests failed" sim.log && exit 1 || exit 0
